// File: Bender.yml
package:
  name: dbg_axi_wrap

sources:
  - source/bus_pkg.sv
  - source/dbg_pkg.sv
  - source/dbg_tap.sv
  - source/dbg_axi_master.sv
  - source/irq_capture.sv
  - source/dbg_axi_wrap.sv
  - target: test
    files:
      - bench/dbg_axi_wrap_assertions.sv
      - bench/tb_dbg_axi_wrap.sv

// File: bench/dbg_axi_wrap_assertions.sv
// Protocol checks for the debug access subsystem.
// AXI valid/ready rules, reset values and the JTAG output enable.

`timescale 1ns/100ps
`default_nettype none

module dbg_axi_wrap_assertions (
  input logic           clk_i,
  input logic           arst_n_i,
  input logic           trst_n_i,
  input logic           tdo_en_i,
  input logic           aw_valid_i,
  input logic           aw_ready_i,
  input bus_pkg::addr_t aw_addr_i,
  input logic           w_valid_i,
  input logic           w_ready_i,
  input bus_pkg::data_t w_data_i,
  input logic           b_valid_i,
  input logic           b_ready_i,
  input logic           ar_valid_i,
  input logic           ar_ready_i,
  input bus_pkg::addr_t ar_addr_i,
  input logic           r_valid_i,
  input logic           r_ready_i
);

  int unsigned fail_count = 0;

  // **************************************************
  // AXI channels
  // **************************************************

  aw_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_addr_i))
  else begin
    $error("AW valid or address changed before ready");
    fail_count = fail_count + 1;
  end

  w_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_data_i))
  else begin
    $error("W valid or data changed before ready");
    fail_count = fail_count + 1;
  end

  ar_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
  else begin
    $error("AR valid or address changed before ready");
    fail_count = fail_count + 1;
  end

  // Read only once the write channels are quiet.
  ar_alone: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ar_valid_i |-> !(aw_valid_i || w_valid_i))
  else begin
    $error("AR valid while a write is pending");
    fail_count = fail_count + 1;
  end

  reset_quiet: assert property (@(posedge clk_i) $rose(arst_n_i) |->
    !(aw_valid_i || aw_ready_i || w_valid_i || w_ready_i || b_valid_i ||
      b_ready_i || ar_valid_i || ar_ready_i || r_valid_i || r_ready_i))
  else begin
    $error("valid or ready high right after reset");
    fail_count = fail_count + 1;
  end

  // **************************************************
  // JTAG
  // **************************************************

  // trst reaches the TAP through the two-flop pin synchronizer.
  trst_quiet: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(trst_n_i || $past(trst_n_i) || $past(trst_n_i, 2) || $past(trst_n_i, 3))
    |-> !tdo_en_i)
  else begin
    $error("tdo enable high while trst_n is low");
    fail_count = fail_count + 1;
  end

endmodule

`default_nettype wire

// File: bench/tb_dbg_axi_wrap.sv
// Testbench for the debug access subsystem.
// Drives JTAG scans and serves the AXI port from a memory model with
// random ready delays.

`timescale 1ns/100ps
`default_nettype none

module tb_dbg_axi_wrap;

  import bus_pkg::*;
  import dbg_pkg::*;

  localparam int    TIMEOUT   = 4000;
  localparam addr_t ERR_BASE  = 32'h1000_0000;

  logic clk_i;
  logic arst_n_i;
  irq_t ext_int_i;
  logic jtag_tck_i;
  logic jtag_tms_i;
  logic jtag_tdi_i;
  logic jtag_trst_n_i;
  logic jtag_tdo_o;
  logic jtag_tdo_en_o;
  addr_t  axi_aw_addr_o;
  len_t   axi_aw_len_o;
  size_t  axi_aw_size_o;
  burst_t axi_aw_burst_o;
  logic   axi_aw_valid_o;
  logic   axi_aw_ready_i;
  data_t  axi_w_data_o;
  strb_t  axi_w_strb_o;
  logic   axi_w_last_o;
  logic   axi_w_valid_o;
  logic   axi_w_ready_i;
  resp_t  axi_b_resp_i;
  logic   axi_b_valid_i;
  logic   axi_b_ready_o;
  addr_t  axi_ar_addr_o;
  len_t   axi_ar_len_o;
  size_t  axi_ar_size_o;
  burst_t axi_ar_burst_o;
  logic   axi_ar_valid_o;
  logic   axi_ar_ready_i;
  data_t  axi_r_data_i;
  resp_t  axi_r_resp_i;
  logic   axi_r_last_i;
  logic   axi_r_valid_i;
  logic   axi_r_ready_o;

  data_t       mem [256];
  int unsigned lcg_state;
  logic        stall;
  logic        aw_got;
  logic        w_got;
  logic        rd_pend;
  logic        b_hs;
  logic        r_hs;
  addr_t       wr_addr;
  data_t       wr_data;
  addr_t       rd_addr;
  int          aw_count;
  int          b_count;
  int          r_count;
  int          aw_dly;
  int          w_dly;
  int          ar_dly;
  int          b_dly;
  int          r_dly;

  dbg_axi_wrap uut (.*);

  bind dbg_axi_wrap dbg_axi_wrap_assertions protocol_checks (
    .clk_i      ( clk_i          ),
    .arst_n_i   ( arst_n_i       ),
    .trst_n_i   ( jtag_trst_n_i  ),
    .tdo_en_i   ( jtag_tdo_en_o  ),
    .aw_valid_i ( axi_aw_valid_o ),
    .aw_ready_i ( axi_aw_ready_i ),
    .aw_addr_i  ( axi_aw_addr_o  ),
    .w_valid_i  ( axi_w_valid_o  ),
    .w_ready_i  ( axi_w_ready_i  ),
    .w_data_i   ( axi_w_data_o   ),
    .b_valid_i  ( axi_b_valid_i  ),
    .b_ready_i  ( axi_b_ready_o  ),
    .ar_valid_i ( axi_ar_valid_o ),
    .ar_ready_i ( axi_ar_ready_i ),
    .ar_addr_i  ( axi_ar_addr_o  ),
    .r_valid_i  ( axi_r_valid_i  ),
    .r_ready_i  ( axi_r_ready_o  )
  );

  always #4 clk_i = ~clk_i;

  // **************************************************
  // Helpers
  // **************************************************

  function automatic int unsigned next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int random_delay();
    return (next_random() >> 16) % 4;
  endfunction

  // Access capture layout is busy, response, read data, zero.
  function automatic logic [64:0] status_word(logic busy, resp_t resp, data_t rdata);
    return {29'd0, busy, resp, rdata, 1'b0};
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [64:0] got,
                             input logic [64:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic wait_responses(input int b_target, input int r_target);
    int cycles;
    cycles = 0;
    while ((b_count < b_target || r_count < r_target) && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (cycles >= TIMEOUT) begin
      fail_run("timeout waiting for an AXI response handshake");
    end
  endtask

  task automatic wait_aw_valid();
    int cycles;
    cycles = 0;
    while (!axi_aw_valid_o && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (cycles >= TIMEOUT) begin
      fail_run("timeout waiting for AW valid");
    end
  endtask

  // **************************************************
  // JTAG bit-banging
  // **************************************************

  // One tck period; tdo is sampled just before the rising edge.
  task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
    jtag_tck_i = 1'b0;
    jtag_tms_i = tms;
    jtag_tdi_i = tdi;
    repeat (4) @(negedge clk_i);
    tdo = jtag_tdo_o;
    jtag_tck_i = 1'b1;
    repeat (4) @(negedge clk_i);
  endtask

  task automatic jtag_reset();
    logic tdo;
    jtag_trst_n_i = 1'b0;
    repeat (4) @(negedge clk_i);
    jtag_trst_n_i = 1'b1;
    repeat (5) tck_cycle(1'b1, 1'b0, tdo);
    tck_cycle(1'b0, 1'b0, tdo);
  endtask

  task automatic shift_ir(input ir_t ir, output ir_t captured);
    logic tdo;
    tck_cycle(1'b1, 1'b0, tdo);
    tck_cycle(1'b1, 1'b0, tdo);
    tck_cycle(1'b0, 1'b0, tdo);
    tck_cycle(1'b0, 1'b0, tdo);
    for (int i = 0; i < IR_W; i++) begin
      tck_cycle(i == IR_W - 1, ir[i], tdo);
      captured[i] = tdo;
    end
    tck_cycle(1'b1, 1'b0, tdo);
    tck_cycle(1'b0, 1'b0, tdo);
  endtask

  task automatic shift_dr(input logic [64:0] din, input int len, output logic [64:0] dout);
    logic tdo;
    dout = '0;
    tck_cycle(1'b1, 1'b0, tdo);
    tck_cycle(1'b0, 1'b0, tdo);
    tck_cycle(1'b0, 1'b0, tdo);
    for (int i = 0; i < len; i++) begin
      tck_cycle(i == len - 1, din[i], tdo);
      dout[i] = tdo;
    end
    tck_cycle(1'b1, 1'b0, tdo);
    tck_cycle(1'b0, 1'b0, tdo);
  endtask

  // **************************************************
  // AXI memory model
  // **************************************************

  task automatic step_ready(input logic valid, inout int dly, output logic ready);
    if (!valid) begin
      ready = 1'b0;
      dly   = random_delay();
    end else if (stall || dly != 0) begin
      ready = 1'b0;
      dly   = stall ? dly : dly - 1;
    end else begin
      ready = 1'b1;
    end
  endtask

  // Handshakes as seen at the rising edge.
  // Every beat is single, four bytes wide, INCR, with full strobes.
  always @(posedge clk_i) begin
    if (axi_aw_valid_o && axi_aw_ready_i) begin
      check_value("axi_aw_len_o", axi_aw_len_o, 0);
      check_value("axi_aw_size_o", axi_aw_size_o, SIZE_4B);
      check_value("axi_aw_burst_o", axi_aw_burst_o, BURST_INCR);
      wr_addr  = axi_aw_addr_o;
      aw_got   = 1'b1;
      aw_count = aw_count + 1;
    end
    if (axi_w_valid_o && axi_w_ready_i) begin
      check_value("axi_w_strb_o", axi_w_strb_o, 4'hF);
      check_value("axi_w_last_o", axi_w_last_o, 1'b1);
      wr_data = axi_w_data_o;
      w_got   = 1'b1;
    end
    if (axi_b_valid_i && axi_b_ready_o) begin
      b_hs    = 1'b1;
      b_count = b_count + 1;
    end
    if (axi_ar_valid_o && axi_ar_ready_i) begin
      check_value("axi_ar_len_o", axi_ar_len_o, 0);
      check_value("axi_ar_size_o", axi_ar_size_o, SIZE_4B);
      check_value("axi_ar_burst_o", axi_ar_burst_o, BURST_INCR);
      rd_addr = axi_ar_addr_o;
      rd_pend = 1'b1;
    end
    if (axi_r_valid_i && axi_r_ready_o) begin
      r_hs    = 1'b1;
      r_count = r_count + 1;
    end
  end

  always @(negedge clk_i) begin
    step_ready(axi_aw_valid_o, aw_dly, axi_aw_ready_i);
    step_ready(axi_w_valid_o, w_dly, axi_w_ready_i);
    step_ready(axi_ar_valid_o, ar_dly, axi_ar_ready_i);
    if (b_hs) begin
      axi_b_valid_i = 1'b0;
      b_hs          = 1'b0;
    end else if (aw_got && w_got && !axi_b_valid_i) begin
      if (b_dly > 0) begin
        b_dly = b_dly - 1;
      end else begin
        if (wr_addr < ERR_BASE) begin
          mem[wr_addr[9:2]] = wr_data;
        end
        axi_b_resp_i  = (wr_addr < ERR_BASE) ? RESP_OKAY : RESP_SLVERR;
        axi_b_valid_i = 1'b1;
        aw_got        = 1'b0;
        w_got         = 1'b0;
        b_dly         = random_delay();
      end
    end
    if (r_hs) begin
      axi_r_valid_i = 1'b0;
      r_hs          = 1'b0;
    end else if (rd_pend && !axi_r_valid_i) begin
      if (r_dly > 0) begin
        r_dly = r_dly - 1;
      end else begin
        axi_r_data_i  = (rd_addr < ERR_BASE) ? mem[rd_addr[9:2]] : '0;
        axi_r_resp_i  = (rd_addr < ERR_BASE) ? RESP_OKAY : RESP_SLVERR;
        axi_r_valid_i = 1'b1;
        rd_pend       = 1'b0;
        r_dly         = random_delay();
      end
    end
  end

  always @(negedge clk_i) begin
    if (uut.protocol_checks.fail_count != 0) begin
      $display("an AXI or JTAG protocol assertion failed");
      $display("TEST FAILED");
      $fatal(1, "protocol assertion");
    end
  end

  // **************************************************
  // Stimulus
  // **************************************************

  initial begin
    logic [64:0] out;
    logic        tdo_bit;
    ir_t         ir_out;
    addr_t       addr;
    data_t       data;
    data_t       data2;
    irq_t        irq_lines;
    irq_t        clr;
    int unsigned idx;
    int          aw_base;
    int          b_base;
    int          r_base;

    clk_i          = 1'b0;
    arst_n_i       = 1'b0;
    ext_int_i      = '0;
    jtag_tck_i     = 1'b0;
    jtag_tms_i     = 1'b1;
    jtag_tdi_i     = 1'b0;
    jtag_trst_n_i  = 1'b0;
    axi_aw_ready_i = 1'b0;
    axi_w_ready_i  = 1'b0;
    axi_b_resp_i   = RESP_OKAY;
    axi_b_valid_i  = 1'b0;
    axi_ar_ready_i = 1'b0;
    axi_r_data_i   = '0;
    axi_r_resp_i   = RESP_OKAY;
    axi_r_last_i   = 1'b1;
    axi_r_valid_i  = 1'b0;
    lcg_state      = 5018;
    stall          = 1'b0;
    aw_got         = 1'b0;
    w_got          = 1'b0;
    rd_pend        = 1'b0;
    b_hs           = 1'b0;
    r_hs           = 1'b0;
    aw_count       = 0;
    b_count        = 0;
    r_count        = 0;
    aw_dly         = 0;
    w_dly          = 0;
    ar_dly         = 0;
    b_dly          = 0;
    r_dly          = 0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = {8'hC3, 8'(i), ~8'(i), 8'(i)};
    end
    repeat (4) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);

    // Identification and bypass.
    jtag_reset();
    shift_dr('0, 32, out);
    check_value("idcode", out, IDCODE_VALUE);
    shift_ir(IR_BYPASS, ir_out);
    check_value("ir_capture", ir_out, 5'b00001);
    data = next_random();
    shift_dr(65'(data), 32, out);
    check_value("bypass_tdo", out, {data[30:0], 1'b0});

    // Test reset in the middle of a DR scan.
    tck_cycle(1'b1, 1'b0, tdo_bit);
    tck_cycle(1'b0, 1'b0, tdo_bit);
    tck_cycle(1'b0, 1'b0, tdo_bit);
    tck_cycle(1'b0, 1'b0, tdo_bit);
    jtag_reset();
    shift_dr('0, 32, out);
    check_value("idcode", out, IDCODE_VALUE);

    // Write then read back an in-range word.
    shift_ir(IR_ACCESS, ir_out);
    idx    = (next_random() >> 8) % 256;
    addr   = idx * 4;
    data   = next_random();
    b_base = b_count;
    r_base = r_count;
    shift_dr({data, addr, 1'b1}, 65, out);
    wait_responses(b_base + 1, r_base);
    check_value("mem", mem[idx], data);
    shift_dr({32'd0, addr, 1'b0}, 65, out);
    check_value("access_capture", out, status_word(1'b0, RESP_OKAY, '0));
    wait_responses(b_base + 1, r_base + 1);
    shift_dr({32'd0, addr, 1'b0}, 65, out);
    check_value("access_capture", out, status_word(1'b0, RESP_OKAY, data));
    wait_responses(b_base + 1, r_base + 2);

    // Out-of-range write answers SLVERR.
    shift_dr({data, ERR_BASE + (next_random() & 32'hFFC), 1'b1}, 65, out);
    wait_responses(b_base + 2, r_base + 2);
    shift_dr({32'd0, addr, 1'b0}, 65, out);
    check_value("access_capture", out, status_word(1'b0, RESP_SLVERR, data));
    wait_responses(b_base + 2, r_base + 3);

    // Second access while the first is stalled.
    stall   = 1'b1;
    aw_base = aw_count;
    b_base  = b_count;
    r_base  = r_count;
    data2   = next_random();
    shift_dr({data2, addr, 1'b1}, 65, out);
    check_value("access_capture", out, status_word(1'b0, RESP_OKAY, data));
    wait_aw_valid();
    shift_dr({~data2, addr, 1'b1}, 65, out);
    check_value("access_capture", out, status_word(1'b1, RESP_OKAY, data));
    stall = 1'b0;
    wait_responses(b_base + 1, r_base);
    shift_dr({32'd0, addr, 1'b0}, 65, out);
    check_value("access_capture", out, status_word(1'b0, RESP_OKAY, data));
    wait_responses(b_base + 1, r_base + 1);
    check_value("aw_count", aw_count, aw_base + 1);
    check_value("mem", mem[idx], data2);

    // Sticky interrupts and masked clear.
    shift_ir(IR_IRQ, ir_out);
    irq_lines = 40'h80_0010_0081;
    clr       = 40'h80_0000_0080;
    ext_int_i = irq_lines;
    repeat (2) @(negedge clk_i);
    ext_int_i = '0;
    shift_dr(65'(clr), IRQ_DR_W, out);
    check_value("irq_capture", out, irq_lines);
    shift_dr('0, IRQ_DR_W, out);
    check_value("irq_capture", out, irq_lines & ~clr);

    if (uut.protocol_checks.fail_count == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "protocol assertion");
    end
  end

endmodule

`default_nettype wire

// File: dbg_axi_wrap.f
source/bus_pkg.sv
source/dbg_pkg.sv
source/dbg_tap.sv
source/dbg_axi_master.sv
source/irq_capture.sv
source/dbg_axi_wrap.sv
bench/dbg_axi_wrap_assertions.sv
bench/tb_dbg_axi_wrap.sv

// File: source/bus_pkg.sv
// AXI-side definitions for the debug subsystem.
// Vector types for the manager port plus burst, size and response codes.

`default_nettype none

package bus_pkg;

  // **************************************************
  // Channel field types
  // **************************************************

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  resp_t;
  typedef logic [7:0]  len_t;
  typedef logic [2:0]  size_t;
  typedef logic [1:0]  burst_t;

  // **************************************************
  // Encodings
  // **************************************************

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;
  localparam resp_t RESP_DECERR = 2'b11;

  localparam burst_t BURST_INCR = 2'b01;

  // Four bytes per beat.
  localparam size_t SIZE_4B = 3'b010;

endpackage

`default_nettype wire

// File: source/dbg_axi_master.sv
// Single-beat AXI4 manager for debug bus accesses.
// One 32-bit read or write at a time, with the last response and
// read data held for the TAP.

`timescale 1ns/100ps
`default_nettype none

module dbg_axi_master (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            start_i,
  input  logic            write_i,
  input  bus_pkg::addr_t  addr_i,
  input  bus_pkg::data_t  wdata_i,
  output logic            busy_o,
  output bus_pkg::resp_t  resp_o,
  output bus_pkg::data_t  rdata_o,
  // Write address
  output bus_pkg::addr_t  aw_addr_o,
  output bus_pkg::len_t   aw_len_o,
  output bus_pkg::size_t  aw_size_o,
  output bus_pkg::burst_t aw_burst_o,
  output logic            aw_valid_o,
  input  logic            aw_ready_i,
  // Write data
  output bus_pkg::data_t  w_data_o,
  output bus_pkg::strb_t  w_strb_o,
  output logic            w_last_o,
  output logic            w_valid_o,
  input  logic            w_ready_i,
  // Write response
  input  bus_pkg::resp_t  b_resp_i,
  input  logic            b_valid_i,
  output logic            b_ready_o,
  // Read address
  output bus_pkg::addr_t  ar_addr_o,
  output bus_pkg::len_t   ar_len_o,
  output bus_pkg::size_t  ar_size_o,
  output bus_pkg::burst_t ar_burst_o,
  output logic            ar_valid_o,
  input  logic            ar_ready_i,
  // Read data
  input  bus_pkg::data_t  r_data_i,
  input  bus_pkg::resp_t  r_resp_i,
  input  logic            r_last_i,
  input  logic            r_valid_i,
  output logic            r_ready_o
);

  import bus_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE,
    ST_WRESP,
    ST_RADDR,
    ST_RDATA
  } state_e;

  state_e state_q;
  logic   aw_done_q;
  logic   w_done_q;
  logic   aw_done;
  logic   w_done;
  addr_t  addr_q;
  data_t  wdata_q;

  // AW and W complete independently.
  assign aw_done = aw_done_q | (aw_valid_o & aw_ready_i);
  assign w_done  = w_done_q | (w_valid_o & w_ready_i);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= ST_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      resp_o    <= RESP_OKAY;
      rdata_o   <= '0;
    end else begin
      case (state_q)
        // Starts while busy are dropped.
        ST_IDLE: begin
          if (start_i) begin
            state_q <= write_i ? ST_WRITE : ST_RADDR;
          end
        end
        ST_WRITE: begin
          if (aw_done && w_done) begin
            state_q   <= ST_WRESP;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
          end else begin
            aw_done_q <= aw_done;
            w_done_q  <= w_done;
          end
        end
        ST_WRESP: begin
          if (b_valid_i) begin
            state_q <= ST_IDLE;
            resp_o  <= b_resp_i;
          end
        end
        ST_RADDR: begin
          if (ar_ready_i) begin
            state_q <= ST_RDATA;
          end
        end
        ST_RDATA: begin
          if (r_valid_i) begin
            resp_o  <= r_resp_i;
            rdata_o <= r_data_i;
            if (r_last_i) begin
              state_q <= ST_IDLE;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Request capture.
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && start_i) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
  end

  assign busy_o = (state_q != ST_IDLE);

  assign aw_addr_o  = addr_q;
  assign aw_len_o   = '0;
  assign aw_size_o  = SIZE_4B;
  assign aw_burst_o = BURST_INCR;
  assign aw_valid_o = (state_q == ST_WRITE) && !aw_done_q;

  assign w_data_o  = wdata_q;
  assign w_strb_o  = '1;
  assign w_last_o  = 1'b1;
  assign w_valid_o = (state_q == ST_WRITE) && !w_done_q;

  assign b_ready_o = (state_q == ST_WRESP);

  assign ar_addr_o  = addr_q;
  assign ar_len_o   = '0;
  assign ar_size_o  = SIZE_4B;
  assign ar_burst_o = BURST_INCR;
  assign ar_valid_o = (state_q == ST_RADDR);

  assign r_ready_o = (state_q == ST_RDATA);

endmodule

`default_nettype wire

// File: source/dbg_axi_wrap.sv
// Debug access subsystem top level.
// Connects the JTAG TAP, the AXI4 bus master and the interrupt capture
// to the outside pins.

`timescale 1ns/100ps
`default_nettype none

module dbg_axi_wrap (
  input  logic            clk_i,
  input  logic            arst_n_i,
  // External interrupts
  input  dbg_pkg::irq_t   ext_int_i,
  // JTAG
  input  logic            jtag_tck_i,
  input  logic            jtag_tms_i,
  input  logic            jtag_tdi_i,
  input  logic            jtag_trst_n_i,
  output logic            jtag_tdo_o,
  output logic            jtag_tdo_en_o,
  // AXI manager
  output bus_pkg::addr_t  axi_aw_addr_o,
  output bus_pkg::len_t   axi_aw_len_o,
  output bus_pkg::size_t  axi_aw_size_o,
  output bus_pkg::burst_t axi_aw_burst_o,
  output logic            axi_aw_valid_o,
  input  logic            axi_aw_ready_i,
  output bus_pkg::data_t  axi_w_data_o,
  output bus_pkg::strb_t  axi_w_strb_o,
  output logic            axi_w_last_o,
  output logic            axi_w_valid_o,
  input  logic            axi_w_ready_i,
  input  bus_pkg::resp_t  axi_b_resp_i,
  input  logic            axi_b_valid_i,
  output logic            axi_b_ready_o,
  output bus_pkg::addr_t  axi_ar_addr_o,
  output bus_pkg::len_t   axi_ar_len_o,
  output bus_pkg::size_t  axi_ar_size_o,
  output bus_pkg::burst_t axi_ar_burst_o,
  output logic            axi_ar_valid_o,
  input  logic            axi_ar_ready_i,
  input  bus_pkg::data_t  axi_r_data_i,
  input  bus_pkg::resp_t  axi_r_resp_i,
  input  logic            axi_r_last_i,
  input  logic            axi_r_valid_i,
  output logic            axi_r_ready_o
);

  import bus_pkg::*;
  import dbg_pkg::*;

  logic  access_start;
  logic  access_write;
  addr_t access_addr;
  data_t access_wdata;
  logic  busy;
  resp_t resp;
  data_t rdata;
  logic  irq_clear;
  irq_t  irq_clear_mask;
  irq_t  pending;

  dbg_tap dbg_tap_i (
    .clk_i            ( clk_i          ),
    .arst_n_i         ( arst_n_i       ),
    .tck_i            ( jtag_tck_i     ),
    .tms_i            ( jtag_tms_i     ),
    .tdi_i            ( jtag_tdi_i     ),
    .trst_n_i         ( jtag_trst_n_i  ),
    .tdo_o            ( jtag_tdo_o     ),
    .tdo_en_o         ( jtag_tdo_en_o  ),
    .access_start_o   ( access_start   ),
    .access_write_o   ( access_write   ),
    .access_addr_o    ( access_addr    ),
    .access_wdata_o   ( access_wdata   ),
    .busy_i           ( busy           ),
    .resp_i           ( resp           ),
    .rdata_i          ( rdata          ),
    .irq_clear_o      ( irq_clear      ),
    .irq_clear_mask_o ( irq_clear_mask ),
    .pending_i        ( pending        )
  );

  dbg_axi_master dbg_axi_master_i (
    .clk_i      ( clk_i          ),
    .arst_n_i   ( arst_n_i       ),
    .start_i    ( access_start   ),
    .write_i    ( access_write   ),
    .addr_i     ( access_addr    ),
    .wdata_i    ( access_wdata   ),
    .busy_o     ( busy           ),
    .resp_o     ( resp           ),
    .rdata_o    ( rdata          ),
    .aw_addr_o  ( axi_aw_addr_o  ),
    .aw_len_o   ( axi_aw_len_o   ),
    .aw_size_o  ( axi_aw_size_o  ),
    .aw_burst_o ( axi_aw_burst_o ),
    .aw_valid_o ( axi_aw_valid_o ),
    .aw_ready_i ( axi_aw_ready_i ),
    .w_data_o   ( axi_w_data_o   ),
    .w_strb_o   ( axi_w_strb_o   ),
    .w_last_o   ( axi_w_last_o   ),
    .w_valid_o  ( axi_w_valid_o  ),
    .w_ready_i  ( axi_w_ready_i  ),
    .b_resp_i   ( axi_b_resp_i   ),
    .b_valid_i  ( axi_b_valid_i  ),
    .b_ready_o  ( axi_b_ready_o  ),
    .ar_addr_o  ( axi_ar_addr_o  ),
    .ar_len_o   ( axi_ar_len_o   ),
    .ar_size_o  ( axi_ar_size_o  ),
    .ar_burst_o ( axi_ar_burst_o ),
    .ar_valid_o ( axi_ar_valid_o ),
    .ar_ready_i ( axi_ar_ready_i ),
    .r_data_i   ( axi_r_data_i   ),
    .r_resp_i   ( axi_r_resp_i   ),
    .r_last_i   ( axi_r_last_i   ),
    .r_valid_i  ( axi_r_valid_i  ),
    .r_ready_o  ( axi_r_ready_o  )
  );

  irq_capture irq_capture_i (
    .clk_i        ( clk_i          ),
    .arst_n_i     ( arst_n_i       ),
    .ext_int_i    ( ext_int_i      ),
    .clear_i      ( irq_clear      ),
    .clear_mask_i ( irq_clear_mask ),
    .pending_o    ( pending        )
  );

endmodule

`default_nettype wire

// File: source/dbg_pkg.sv
// JTAG-side definitions for the debug subsystem.
// TAP states, instruction codes and data register layout.

`default_nettype none

package dbg_pkg;

  // **************************************************
  // TAP controller states
  // **************************************************

  typedef enum logic [3:0] {
    TEST_LOGIC_RESET,
    RUN_TEST_IDLE,
    SELECT_DR_SCAN,
    CAPTURE_DR,
    SHIFT_DR,
    EXIT1_DR,
    PAUSE_DR,
    EXIT2_DR,
    UPDATE_DR,
    SELECT_IR_SCAN,
    CAPTURE_IR,
    SHIFT_IR,
    EXIT1_IR,
    PAUSE_IR,
    EXIT2_IR,
    UPDATE_IR
  } tap_state_e;

  // **************************************************
  // Instructions and data registers
  // **************************************************

  localparam int IR_W = 5;

  typedef logic [IR_W-1:0] ir_t;

  localparam ir_t IR_IDCODE = 5'd1;
  localparam ir_t IR_ACCESS = 5'd2;
  localparam ir_t IR_IRQ    = 5'd3;
  localparam ir_t IR_BYPASS = '1;

  localparam int IDCODE_DR_W = 32;
  localparam int IRQ_DR_W    = 40;
  // Write flag, address, data.
  localparam int ACCESS_DR_W = 65;

  // Bit 0 is fixed to one by the JTAG standard.
  localparam logic [IDCODE_DR_W-1:0] IDCODE_VALUE = 32'h1DB0_5A0B;

  typedef logic [IRQ_DR_W-1:0] irq_t;

endpackage

`default_nettype wire

// File: source/dbg_tap.sv
// JTAG test access port, oversampled on the system clock.
// Runs the TAP controller on detected tck edges and shifts the IR and
// the IDCODE, bus access, interrupt or bypass data register.

`timescale 1ns/100ps
`default_nettype none

module dbg_tap (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           tck_i,
  input  logic           tms_i,
  input  logic           tdi_i,
  input  logic           trst_n_i,
  output logic           tdo_o,
  output logic           tdo_en_o,
  output logic           access_start_o,
  output logic           access_write_o,
  output bus_pkg::addr_t access_addr_o,
  output bus_pkg::data_t access_wdata_o,
  input  logic           busy_i,
  input  bus_pkg::resp_t resp_i,
  input  bus_pkg::data_t rdata_i,
  output logic           irq_clear_o,
  output dbg_pkg::irq_t  irq_clear_mask_o,
  input  dbg_pkg::irq_t  pending_i
);

  import dbg_pkg::*;

  logic [3:0]             sync_q1;
  logic [3:0]             sync_q2;
  logic                   tck_s;
  logic                   tms_s;
  logic                   tdi_s;
  logic                   trst_n_s;
  logic                   tck_prev_q;
  logic                   tck_rise;
  logic                   tck_fall;
  tap_state_e             state_q;
  tap_state_e             state_d;
  ir_t                    ir_q;
  ir_t                    ir_shift_q;
  logic [ACCESS_DR_W-1:0] dr_q;

  // **************************************************
  // Pin synchronizer and tck edge detect
  // **************************************************

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q1    <= '0;
      sync_q2    <= '0;
      tck_prev_q <= 1'b0;
    end else begin
      sync_q1    <= {tck_i, tms_i, tdi_i, trst_n_i};
      sync_q2    <= sync_q1;
      tck_prev_q <= tck_s;
    end
  end

  assign {tck_s, tms_s, tdi_s, trst_n_s} = sync_q2;

  assign tck_rise = tck_s & ~tck_prev_q;
  assign tck_fall = ~tck_s & tck_prev_q;

  // **************************************************
  // TAP controller
  // **************************************************

  always_comb begin
    state_d = state_q;
    case (state_q)
      TEST_LOGIC_RESET: state_d = tms_s ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
      RUN_TEST_IDLE:    state_d = tms_s ? SELECT_DR_SCAN : RUN_TEST_IDLE;
      SELECT_DR_SCAN:   state_d = tms_s ? SELECT_IR_SCAN : CAPTURE_DR;
      CAPTURE_DR:       state_d = tms_s ? EXIT1_DR : SHIFT_DR;
      SHIFT_DR:         state_d = tms_s ? EXIT1_DR : SHIFT_DR;
      EXIT1_DR:         state_d = tms_s ? UPDATE_DR : PAUSE_DR;
      PAUSE_DR:         state_d = tms_s ? EXIT2_DR : PAUSE_DR;
      EXIT2_DR:         state_d = tms_s ? UPDATE_DR : SHIFT_DR;
      UPDATE_DR:        state_d = tms_s ? SELECT_DR_SCAN : RUN_TEST_IDLE;
      SELECT_IR_SCAN:   state_d = tms_s ? TEST_LOGIC_RESET : CAPTURE_IR;
      CAPTURE_IR:       state_d = tms_s ? EXIT1_IR : SHIFT_IR;
      SHIFT_IR:         state_d = tms_s ? EXIT1_IR : SHIFT_IR;
      EXIT1_IR:         state_d = tms_s ? UPDATE_IR : PAUSE_IR;
      PAUSE_IR:         state_d = tms_s ? EXIT2_IR : PAUSE_IR;
      EXIT2_IR:         state_d = tms_s ? UPDATE_IR : SHIFT_IR;
      UPDATE_IR:        state_d = tms_s ? SELECT_DR_SCAN : RUN_TEST_IDLE;
      default:          state_d = TEST_LOGIC_RESET;
    endcase
  end

  // Shift and step on rising tck, drive tdo and update on falling tck.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q        <= TEST_LOGIC_RESET;
      ir_q           <= IR_IDCODE;
      ir_shift_q     <= '0;
      tdo_o          <= 1'b0;
      tdo_en_o       <= 1'b0;
      access_start_o <= 1'b0;
      irq_clear_o    <= 1'b0;
    end else if (!trst_n_s) begin
      state_q        <= TEST_LOGIC_RESET;
      ir_q           <= IR_IDCODE;
      tdo_en_o       <= 1'b0;
      access_start_o <= 1'b0;
      irq_clear_o    <= 1'b0;
    end else begin
      access_start_o <= 1'b0;
      irq_clear_o    <= 1'b0;
      if (tck_rise) begin
        case (state_q)
          TEST_LOGIC_RESET: ir_q <= IR_IDCODE;
          // Standard capture pattern 01 in the low bits.
          CAPTURE_IR:       ir_shift_q <= ir_t'(1);
          SHIFT_IR:         ir_shift_q <= {tdi_s, ir_shift_q[IR_W-1:1]};
          default:          ;
        endcase
        state_q <= state_d;
      end
      if (tck_fall) begin
        tdo_en_o <= (state_q == SHIFT_IR) || (state_q == SHIFT_DR);
        tdo_o    <= (state_q == SHIFT_IR) ? ir_shift_q[0] : dr_q[0];
        if (state_q == UPDATE_IR) begin
          ir_q <= ir_shift_q;
        end
        if (state_q == UPDATE_DR) begin
          access_start_o <= (ir_q == IR_ACCESS);
          irq_clear_o    <= (ir_q == IR_IRQ);
        end
      end
    end
  end

  // **************************************************
  // Data registers
  // **************************************************

  // One shift chain, LSB first; its length follows the instruction.
  always_ff @(posedge clk_i) begin
    if (tck_rise && state_q == CAPTURE_DR) begin
      case (ir_q)
        IR_IDCODE: dr_q <= ACCESS_DR_W'(IDCODE_VALUE);
        IR_ACCESS: dr_q <= ACCESS_DR_W'({busy_i, resp_i, rdata_i, 1'b0});
        IR_IRQ:    dr_q <= ACCESS_DR_W'(pending_i);
        default:   dr_q <= '0;
      endcase
    end else if (tck_rise && state_q == SHIFT_DR) begin
      case (ir_q)
        IR_IDCODE: dr_q[IDCODE_DR_W-1:0] <= {tdi_s, dr_q[IDCODE_DR_W-1:1]};
        IR_ACCESS: dr_q <= {tdi_s, dr_q[ACCESS_DR_W-1:1]};
        IR_IRQ:    dr_q[IRQ_DR_W-1:0] <= {tdi_s, dr_q[IRQ_DR_W-1:1]};
        default:   dr_q[0] <= tdi_s;
      endcase
    end
    if (tck_fall && state_q == UPDATE_DR) begin
      if (ir_q == IR_ACCESS) begin
        access_write_o <= dr_q[0];
        access_addr_o  <= dr_q[32:1];
        access_wdata_o <= dr_q[64:33];
      end
      if (ir_q == IR_IRQ) begin
        irq_clear_mask_o <= dr_q[IRQ_DR_W-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/irq_capture.sv
// External interrupt capture.
// Synchronizes the interrupt lines and holds sticky pending bits.

`timescale 1ns/100ps
`default_nettype none

module irq_capture (
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  dbg_pkg::irq_t ext_int_i,
  input  logic          clear_i,
  input  dbg_pkg::irq_t clear_mask_i,
  output dbg_pkg::irq_t pending_o
);

  import dbg_pkg::*;

  irq_t sync_q1;
  irq_t sync_q2;
  irq_t clear_bits;

  assign clear_bits = clear_i ? clear_mask_i : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q1   <= '0;
      sync_q2   <= '0;
      pending_o <= '0;
    end else begin
      sync_q1   <= ext_int_i;
      sync_q2   <= sync_q1;
      // Set wins over clear.
      pending_o <= (pending_o & ~clear_bits) | sync_q2;
    end
  end

endmodule

`default_nettype wire
